// ==== design/queue_pkg.sv ====
package queue_pkg;

    typedef logic [63:0] word_t;
    typedef logic [7:0]  byte_en_t;

    localparam int ring_words = 64;

    typedef logic [$clog2(ring_words)-1:0] ring_idx_t;

    localparam int         valid_byte_lsb = 56;
    localparam logic [7:0] entry_valid    = 8'h80;
    localparam logic [7:0] entry_free     = 8'h00;

    // Enable for the valid byte alone.
    localparam byte_en_t valid_be = byte_en_t'(1) << (valid_byte_lsb / 8);

endpackage

// ==== design/cmd_fmt_pkg.sv ====
package cmd_fmt_pkg;

    typedef enum logic [7:0] {
        exec_task_code      = 8'h01,
        setup_hw_inst_code  = 8'h02,
        exec_peri_task_code = 8'h03
    } cmd_code_t;

    typedef logic [7:0] acc_id_t;

    localparam int code_lsb   = 0;
    localparam int nargs_lsb  = 8;
    localparam int acc_id_lsb = 32;

    // Length in words, header included.
    function automatic logic [9:0] cmd_len(cmd_code_t code, logic [7:0] nargs);
        logic [9:0] arg_words;
        arg_words = {1'b0, nargs, 1'b0};
        case (code)
            exec_task_code:      return 10'd3 + arg_words;
            exec_peri_task_code: return 10'd4 + arg_words;
            setup_hw_inst_code:  return 10'd2;
            default:             return 10'd1; // Header only.
        endcase
    endfunction

    function automatic logic [9:0] hdr_words(logic [63:0] hdr);
        return cmd_len(cmd_code_t'(hdr[code_lsb +: 8]), hdr[nargs_lsb +: 8]);
    endfunction

endpackage

// ==== design/cmd_queue_ram.sv ====
`timescale 1ns/1ns

module cmd_queue_ram #(
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic                     a_en,
    input  queue_pkg::byte_en_t      a_we,
    input  logic [$clog2(depth)-1:0] a_addr,
    input  queue_pkg::word_t         a_wdata,
    output queue_pkg::word_t         a_rdata,
    input  logic                     b_en,
    input  queue_pkg::byte_en_t      b_we,
    input  logic [$clog2(depth)-1:0] b_addr,
    input  queue_pkg::word_t         b_wdata,
    output queue_pkg::word_t         b_rdata
);

    queue_pkg::word_t mem [depth];

    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(queue_pkg::byte_en_t); i++) begin
            if (a_en && a_we[i]) begin
                mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
            end
            if (b_en && b_we[i]) begin
                mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
            end
        end
        if (a_en) begin
            a_rdata <= mem[a_addr]; // Read-first.
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

    // Writer fills free slots while the reader retires committed ones.
    assert property (@(posedge clk) (a_en && |a_we && b_en && |b_we) |-> a_addr != b_addr)
        else $error("cmd_queue_ram: both ports write address %0h", a_addr);

endmodule

// ==== design/cmd_writer.sv ====
`timescale 1ns/1ns

module cmd_writer #(
    parameter int num_accs   = 4,
    parameter int in_credits = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  queue_pkg::word_t            in_data,
    output logic                        in_credit,
    output logic                        a_en,
    output queue_pkg::byte_en_t         a_we,
    output logic [$clog2(num_accs)+5:0] a_addr,
    output queue_pkg::word_t            a_wdata,
    input  queue_pkg::word_t            a_rdata
);

    localparam int acc_w = $clog2(num_accs);
    localparam int ptr_w = $clog2(in_credits);
    localparam int cnt_w = $clog2(in_credits + 1);

    typedef enum logic [1:0] {st_idle, st_reclaim, st_body, st_header} state_t;

    state_t state;

    queue_pkg::word_t fifo_mem [in_credits];
    logic [ptr_w-1:0] fifo_wp;
    logic [ptr_w-1:0] fifo_rp;
    logic [cnt_w-1:0] fifo_cnt;
    logic             have_word;
    logic             take_hdr;
    logic             pop;

    queue_pkg::ring_idx_t wr_idx   [num_accs];
    queue_pkg::ring_idx_t rd_idx   [num_accs];
    logic [6:0]           free_cnt [num_accs];

    queue_pkg::word_t     head;
    logic [acc_w-1:0]     head_acc;
    logic [9:0]           head_len;
    logic [9:0]           rb_len;
    logic                 room;
    queue_pkg::word_t     hdr_q;
    logic [acc_w-1:0]     hdr_acc;
    logic [9:0]           hdr_len;
    queue_pkg::ring_idx_t body_idx;
    logic [6:0]           body_left;

    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] p);
        return (p == ptr_w'(in_credits - 1)) ? '0 : p + 1'b1;
    endfunction

    assign have_word = fifo_cnt != '0;
    assign head      = fifo_mem[fifo_rp];
    assign head_acc  = head[cmd_fmt_pkg::acc_id_lsb +: acc_w];
    assign head_len  = cmd_fmt_pkg::hdr_words(head);
    assign rb_len    = cmd_fmt_pkg::hdr_words(a_rdata);
    assign hdr_acc   = hdr_q[cmd_fmt_pkg::acc_id_lsb +: acc_w];
    assign hdr_len   = cmd_fmt_pkg::hdr_words(hdr_q);

    // One slot stays spare for the next header.
    assign room     = {3'b000, free_cnt[head_acc]} > head_len;
    assign take_hdr = state == st_idle && have_word && room;
    assign pop      = take_hdr || (state == st_body && have_word);

    always_comb begin
        a_en    = 1'b0;
        a_we    = '0;
        a_addr  = {head_acc, rd_idx[head_acc]}; // Oldest header, for reclaim.
        a_wdata = '0;
        case (state)
            st_idle: begin
                a_en = have_word;
                if (room) begin
                    // Invalidate the slot where the next header will go.
                    a_we   = have_word ? queue_pkg::valid_be : '0;
                    a_addr = {head_acc, wr_idx[head_acc] + head_len[5:0]};
                    a_wdata[queue_pkg::valid_byte_lsb +: 8] = queue_pkg::entry_free;
                end
            end
            st_body: begin
                a_en    = have_word;
                a_we    = have_word ? '1 : '0;
                a_addr  = {hdr_acc, body_idx};
                a_wdata = head;
            end
            st_header: begin
                a_en    = 1'b1;
                a_we    = '1;
                a_addr  = {hdr_acc, wr_idx[hdr_acc]};
                a_wdata = hdr_q;
                a_wdata[queue_pkg::valid_byte_lsb +: 8] = queue_pkg::entry_valid;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            fifo_wp   <= '0;
            fifo_rp   <= '0;
            fifo_cnt  <= '0;
            in_credit <= 1'b0;
            for (int i = 0; i < num_accs; i++) begin
                wr_idx[i]   <= '0;
                rd_idx[i]   <= '0;
                free_cnt[i] <= 7'(queue_pkg::ring_words);
            end
        end else begin
            in_credit <= pop; // Credit back per popped word.
            if (in_valid) begin
                fifo_wp <= next_ptr(fifo_wp);
            end
            if (pop) begin
                fifo_rp <= next_ptr(fifo_rp);
            end
            fifo_cnt <= fifo_cnt + in_valid - pop;
            case (state)
                st_idle: begin
                    if (have_word) begin
                        if (!room) begin
                            state <= st_reclaim;
                        end else if (head_len == 10'd1) begin
                            state <= st_header;
                        end else begin
                            state <= st_body;
                        end
                    end
                end
                st_reclaim: begin
                    if (a_rdata[queue_pkg::valid_byte_lsb +: 8] == queue_pkg::entry_free) begin
                        free_cnt[head_acc] <= free_cnt[head_acc] + rb_len[6:0];
                        rd_idx[head_acc]   <= rd_idx[head_acc] + rb_len[5:0];
                    end
                    state <= st_idle; // Check again.
                end
                st_body: begin
                    if (pop && body_left == 7'd1) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    wr_idx[hdr_acc]   <= wr_idx[hdr_acc] + hdr_len[5:0];
                    free_cnt[hdr_acc] <= free_cnt[hdr_acc] - hdr_len[6:0];
                    state             <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[fifo_wp] <= in_data;
        end
        if (take_hdr) begin
            hdr_q     <= head;
            body_idx  <= wr_idx[head_acc] + 6'd1;
            body_left <= head_len[6:0] - 7'd1;
        end else if (state == st_body && pop) begin
            body_idx  <= body_idx + 6'd1;
            body_left <= body_left - 7'd1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> fifo_cnt != in_credits)
        else $error("cmd_writer: host pushed without credit");

    assert property (@(posedge clk) disable iff (!rst_n)
        take_hdr |-> head[cmd_fmt_pkg::code_lsb +: 8] inside {cmd_fmt_pkg::exec_task_code,
            cmd_fmt_pkg::exec_peri_task_code, cmd_fmt_pkg::setup_hw_inst_code})
        else $error("cmd_writer: unknown command code %0h", head[7:0]);

endmodule

// ==== design/cmd_reader.sv ====
`timescale 1ns/1ns

module cmd_reader #(
    parameter int num_accs    = 4,
    parameter int out_credits = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        b_en,
    output queue_pkg::byte_en_t         b_we,
    output logic [$clog2(num_accs)+5:0] b_addr,
    output queue_pkg::word_t            b_wdata,
    input  queue_pkg::word_t            b_rdata,
    output logic                        out_valid,
    output cmd_fmt_pkg::acc_id_t        out_acc,
    output queue_pkg::word_t            out_data,
    output logic                        out_last,
    input  logic                        out_credit
);

    localparam int acc_w = $clog2(num_accs);
    localparam int crd_w = $clog2(out_credits + 1);

    typedef enum logic [1:0] {st_poll, st_check, st_send, st_clear} state_t;

    state_t               state;
    logic [acc_w-1:0]     rr;
    logic [acc_w-1:0]     next_rr;
    queue_pkg::ring_idx_t rd_idx [num_accs];
    queue_pkg::ring_idx_t send_idx;
    logic [9:0]           poll_len;
    logic [9:0]           cur_len;
    logic [9:0]           left;
    logic [crd_w-1:0]     credit_cnt;
    logic                 hdr_valid;

    assign next_rr   = (rr == acc_w'(num_accs - 1)) ? '0 : rr + 1'b1;
    assign hdr_valid = b_rdata[queue_pkg::valid_byte_lsb +: 8] == queue_pkg::entry_valid;
    assign poll_len  = cmd_fmt_pkg::hdr_words(b_rdata);

    // Read data holds while the port idles, so it drives the stream directly.
    assign out_valid = state == st_send && credit_cnt != '0;
    assign out_acc   = cmd_fmt_pkg::acc_id_t'(rr);
    assign out_data  = b_rdata;
    assign out_last  = state == st_send && left == 10'd1;

    always_comb begin
        b_en    = 1'b0;
        b_we    = '0;
        b_addr  = {rr, rd_idx[rr]};
        b_wdata = '0;
        case (state)
            st_poll: b_en = 1'b1;
            st_send: begin
                b_en   = out_valid && !out_last; // Fetch the next word.
                b_addr = {rr, send_idx + 6'd1};
            end
            st_clear: begin
                b_en = 1'b1;
                b_we = queue_pkg::valid_be;
                b_wdata[queue_pkg::valid_byte_lsb +: 8] = queue_pkg::entry_free;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_poll;
            rr         <= '0;
            credit_cnt <= crd_w'(out_credits);
            for (int i = 0; i < num_accs; i++) begin
                rd_idx[i] <= '0;
            end
        end else begin
            credit_cnt <= credit_cnt + out_credit - out_valid;
            case (state)
                st_poll: state <= st_check;
                st_check: begin
                    if (hdr_valid) begin
                        state <= st_send;
                    end else begin
                        rr    <= next_rr; // Nothing here, try the next ring.
                        state <= st_poll;
                    end
                end
                st_send: begin
                    if (out_valid && out_last) begin
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    rd_idx[rr] <= rd_idx[rr] + cur_len[5:0];
                    rr         <= next_rr;
                    state      <= st_poll;
                end
                default: state <= st_poll;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_check) begin
            cur_len  <= poll_len;
            left     <= poll_len;
            send_idx <= rd_idx[rr];
        end else if (out_valid) begin
            left     <= left - 10'd1;
            send_idx <= send_idx + 6'd1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) credit_cnt <= out_credits)
        else $error("cmd_reader: credit count above %0d", out_credits);

endmodule

// ==== design/cmd_queue_top.sv ====
`timescale 1ns/1ns

module cmd_queue_top #(
    parameter int num_accs    = 4,
    parameter int in_credits  = 8,
    parameter int out_credits = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  queue_pkg::word_t     in_data,
    output logic                 in_credit,
    output logic                 out_valid,
    output cmd_fmt_pkg::acc_id_t out_acc,
    output queue_pkg::word_t     out_data,
    output logic                 out_last,
    input  logic                 out_credit
);

    localparam int addr_w = $clog2(num_accs) + 6;

    logic                a_en;
    queue_pkg::byte_en_t a_we;
    logic [addr_w-1:0]   a_addr;
    queue_pkg::word_t    a_wdata;
    queue_pkg::word_t    a_rdata;
    logic                b_en;
    queue_pkg::byte_en_t b_we;
    logic [addr_w-1:0]   b_addr;
    queue_pkg::word_t    b_wdata;
    queue_pkg::word_t    b_rdata;

    cmd_writer #(
        .num_accs   (num_accs),
        .in_credits (in_credits)
    ) u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_credit (in_credit),
        .a_en      (a_en),
        .a_we      (a_we),
        .a_addr    (a_addr),
        .a_wdata   (a_wdata),
        .a_rdata   (a_rdata)
    );

    cmd_queue_ram #(
        .depth (num_accs * queue_pkg::ring_words)
    ) u_ram (
        .clk     (clk),
        .a_en    (a_en),
        .a_we    (a_we),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .a_rdata (a_rdata),
        .b_en    (b_en),
        .b_we    (b_we),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata)
    );

    cmd_reader #(
        .num_accs    (num_accs),
        .out_credits (out_credits)
    ) u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .b_en       (b_en),
        .b_we       (b_we),
        .b_addr     (b_addr),
        .b_wdata    (b_wdata),
        .b_rdata    (b_rdata),
        .out_valid  (out_valid),
        .out_acc    (out_acc),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

endmodule

// ==== tests/tb_cmd_queue.sv ====
`timescale 1ns/1ns

module tb_cmd_queue;

    localparam int num_accs    = 4;
    localparam int in_credits  = 8;
    localparam int out_credits = 4;
    // Words per test: 9, 2 + 4, 32 and 96.
    localparam int total_words = 9 + 6 + 32 + 96;
    localparam int watchdog_ns = (total_words * 40 + 2000) * 20;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    queue_pkg::word_t     in_data;
    logic                 in_credit;
    logic                 out_valid;
    cmd_fmt_pkg::acc_id_t out_acc;
    queue_pkg::word_t     out_data;
    logic                 out_last;
    logic                 out_credit;

    queue_pkg::word_t exp_q  [num_accs][$];
    bit               last_q [num_accs][$];
    int errors           = 0;
    int words_sent       = 0;
    int words_recv       = 0;
    int host_back        = 0;
    int credits_returned = 0;
    bit hold_credits     = 1'b0;

    cmd_queue_top #(
        .num_accs    (num_accs),
        .in_credits  (in_credits),
        .out_credits (out_credits)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_acc    (out_acc),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    always #10 clk = ~clk;

    function automatic int cmd_words(input cmd_fmt_pkg::cmd_code_t code, input int nargs);
        case (code)
            cmd_fmt_pkg::exec_task_code:      return 3 + 2 * nargs;
            cmd_fmt_pkg::exec_peri_task_code: return 4 + 2 * nargs;
            default:                          return 2;
        endcase
    endfunction

    function automatic int host_credits();
        return in_credits - words_sent + host_back;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int a = 0; a < num_accs; a++) begin
            n += exp_q[a].size();
        end
        return n;
    endfunction

    task automatic check_word(input string name, input queue_pkg::word_t exp,
                              input queue_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_acc(input string name, input cmd_fmt_pkg::acc_id_t exp,
                             input cmd_fmt_pkg::acc_id_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic watchdog();
        #(watchdog_ns);
        $display("Timeout after %0d ns with %0d of %0d words delivered",
                 watchdog_ns, words_recv, words_sent);
        $display("Test failed");
        $finish;
    endtask

    task automatic count_host_credits();
        forever begin
            @(negedge clk);
            if (rst_n && in_credit) begin
                host_back++;
            end
        end
    endtask

    // Accelerator returns one credit per word it took.
    task automatic return_credits();
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && !hold_credits && credits_returned < words_recv) begin
                out_credit = 1'b1;
                credits_returned++;
            end else begin
                out_credit = 1'b0;
            end
        end
    endtask

    task automatic watch_output();
        bit                   in_cmd;
        bit                   exp_last;
        cmd_fmt_pkg::acc_id_t cur_acc;
        queue_pkg::word_t     exp_w;
        int                   a;
        in_cmd  = 1'b0;
        cur_acc = '0;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid) begin
                words_recv++;
                a = int'(out_acc);
                if (in_cmd) begin
                    check_acc("out_acc", cur_acc, out_acc); // Contiguous words.
                end
                if (a >= num_accs || exp_q[a].size() == 0) begin
                    $display("Unexpected word %h arrived for accelerator %0d", out_data, a);
                    errors++;
                end else begin
                    exp_w    = exp_q[a].pop_front();
                    exp_last = last_q[a].pop_front();
                    if (!in_cmd) begin
                        check_acc("out_acc", exp_w[cmd_fmt_pkg::acc_id_lsb +: 8], out_acc);
                    end
                    check_word("out_data", exp_w, out_data);
                    if (exp_last && !out_last) begin
                        $display("Final word for accelerator %0d came without out_last", a);
                        errors++;
                    end else if (!exp_last && out_last) begin
                        $display("out_last came before the final word for accelerator %0d", a);
                        errors++;
                    end
                    in_cmd  = !exp_last;
                    cur_acc = out_acc;
                end
            end
        end
    endtask

    task automatic send_word(input queue_pkg::word_t w);
        @(posedge clk);
        #2;
        while (host_credits() == 0) begin
            in_valid = 1'b0; // Out of credit.
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_data  = w;
        words_sent++;
    endtask

    task automatic send_cmd(input cmd_fmt_pkg::cmd_code_t code, input int nargs, input int acc);
        queue_pkg::word_t hdr;
        queue_pkg::word_t w;
        int               len;
        len = cmd_words(code, nargs);
        hdr = '0;
        hdr[7:0]                             = code;
        hdr[cmd_fmt_pkg::nargs_lsb +: 8]     = 8'(nargs);
        hdr[31:16]                           = 16'($urandom);
        hdr[cmd_fmt_pkg::acc_id_lsb +: 8]    = 8'(acc);
        hdr[55:40]                           = 16'($urandom);
        w = hdr;
        w[queue_pkg::valid_byte_lsb +: 8] = queue_pkg::entry_valid; // Set by the writer.
        exp_q[acc].push_back(w);
        last_q[acc].push_back(len == 1);
        send_word(hdr);
        for (int i = 1; i < len; i++) begin
            w = {$urandom, $urandom};
            exp_q[acc].push_back(w);
            last_q[acc].push_back(i == len - 1);
            send_word(w);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_words() != 0) begin
            @(posedge clk);
            #5;
        end
        repeat (20) @(posedge clk);
    endtask

    task automatic test_single_exec();
        int start;
        start = words_recv;
        send_cmd(cmd_fmt_pkg::exec_task_code, 3, 1);
        wait_drain();
        check_count("words_recv", 9, words_recv - start);
    endtask

    task automatic test_short_cmds();
        int start;
        start = words_recv;
        send_cmd(cmd_fmt_pkg::setup_hw_inst_code, 0, 0);
        send_cmd(cmd_fmt_pkg::exec_peri_task_code, 0, 3);
        wait_drain();
        check_count("words_recv", 6, words_recv - start);
    endtask

    task automatic test_interleaved();
        for (int a = 0; a < num_accs; a++) begin
            send_cmd(cmd_fmt_pkg::exec_task_code, a, a);
        end
        for (int a = num_accs - 1; a >= 0; a--) begin
            send_cmd(cmd_fmt_pkg::setup_hw_inst_code, 0, a);
        end
        wait_drain();
    endtask

    task automatic test_back_pressure();
        int stall;
        int waited;
        int leaks;
        hold_credits = 1'b1;
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    send_cmd(cmd_fmt_pkg::exec_task_code, i % 4, 2);
                end
            end
            begin
                stall  = 0;
                waited = 0;
                leaks  = 0;
                while (stall < 20 && waited < 2000) begin
                    @(posedge clk);
                    #5;
                    waited++;
                    stall = (host_credits() == 0) ? stall + 1 : 0;
                end
                if (stall < 20) begin
                    $display("Host credits never ran out while the accelerator held back");
                    errors++;
                end else begin
                    repeat (40) begin
                        @(posedge clk);
                        #5;
                        if (host_credits() != 0) begin
                            leaks++;
                        end
                    end
                    if (leaks != 0) begin
                        $display("Host regained credits while the ring was full");
                        errors++;
                    end
                end
                hold_credits = 1'b0;
            end
        join
        wait_drain();
    endtask

    task automatic test_conservation();
        int waited;
        waited = 0;
        while (host_credits() != in_credits && waited < 200) begin
            @(posedge clk);
            #5;
            waited++;
        end
        check_count("host_credits", in_credits, host_credits());
        check_count("words_recv", words_sent, words_recv);
    endtask

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        void'($urandom(32'h8ccf));
        fork
            watchdog();
            count_host_credits();
            return_credits();
            watch_output();
        join_none
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (in_credit !== 1'b0 || out_valid !== 1'b0) begin
            $display("in_credit or out_valid is not low after reset");
            errors++;
        end
        test_single_exec();
        test_short_cmds();
        test_interleaved();
        test_back_pressure();
        test_conservation();
        $display("Errors: %0d, words sent: %0d, words received: %0d",
                 errors, words_sent, words_recv);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/queue_pkg.sv
design/cmd_fmt_pkg.sv
design/cmd_queue_ram.sv
design/cmd_writer.sv
design/cmd_reader.sv
design/cmd_queue_top.sv
tests/tb_cmd_queue.sv
